/* design/decodeStage_params.svh */
`ifndef DECODE_STAGE_PARAMS_SVH
`define DECODE_STAGE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

`define REG_WIDTH     32  // scalar register data
`define PC_WIDTH      32  // program counter
`define IR_WIDTH      32  // full instruction word
`define OPCODE_WIDTH  8   // ir[31:24]
`define IMM_WIDTH     16  // ir[15:0], sign extended on decode

////////////////////////////////////////////////////////////////////////////
// register file shape
////////////////////////////////////////////////////////////////////////////

`define NUM_REGS      16  // r0..r15
`define REG_IDX_WIDTH 4   // log2 of NUM_REGS

// jsr / jsrr write the return pc here
`define LINK_REG      7

`endif

/* design/isaPkg.sv */
`default_nettype none

`include "decodeStage_params.svh"

// instruction set encodings
package isaPkg;

  // branch opcodes are BR_PREFIX followed by their n/z/p mask
  localparam logic [4:0] BR_PREFIX = 5'b00100;

  typedef enum logic [`OPCODE_WIDTH-1:0] {
    ADD   = 8'h00,
    ADDI  = 8'h01,
    AND   = 8'h02,
    ANDI  = 8'h03,
    MOV   = 8'h04,
    MOVI  = 8'h05,
    LDW   = 8'h10,  // mem load, base in fieldB
    STW   = 8'h11,  // mem store, data in fieldA
    BRP   = 8'h21,  // 00100_001
    BRZ   = 8'h22,  // 00100_010
    BRZP  = 8'h23,
    BRN   = 8'h24,  // 00100_100
    BRNP  = 8'h25,
    BRNZ  = 8'h26,
    BRNZP = 8'h27,  // always taken
    JMP   = 8'h30,
    JSR   = 8'h31,  // pc relative, links r7
    JSRR  = 8'h32   // register target, links r7
  } opcodeE;

  // ir layout, msb first
  typedef struct packed {
    opcodeE                    opcode;  // 31:24
    logic [`REG_IDX_WIDTH-1:0] fieldA;  // 23:20, dest for alu ops
    logic [`REG_IDX_WIDTH-1:0] fieldB;  // 19:16, first source
    logic [`IMM_WIDTH-1:0]     imm;     // 15:0, second source sits in 11:8
  } instrT;

  // one-hot condition code, same bit order as the branch mask
  typedef enum logic [2:0] {
    ccN = 3'b100,
    ccZ = 3'b010,
    ccP = 3'b001
  } condCodeE;

endpackage

`default_nettype wire

/* design/pipePkg.sv */
`default_nettype none

`include "decodeStage_params.svh"

// records passed between pipeline stages
package pipePkg;

  ////////////////////////////////////////////////////////////////////////////
  // writeback to decode
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                      enable;  // scalar write this cycle
    logic [`REG_IDX_WIDTH-1:0] regIdx;
    logic [`REG_WIDTH-1:0]     data;
  } writeBackT;

  ////////////////////////////////////////////////////////////////////////////
  // decode to execute
  ////////////////////////////////////////////////////////////////////////////

  // fields an opcode does not touch hold their last value
  typedef struct packed {
    logic [`PC_WIDTH-1:0]      pc;
    isaPkg::opcodeE            opcode;
    logic [`REG_WIDTH-1:0]     imm;         // sign extended, <<2 for jumps
    logic [`REG_WIDTH-1:0]     src1Value;   // from fieldB
    logic [`REG_WIDTH-1:0]     src2Value;   // from imm[11:8]
    logic [`REG_IDX_WIDTH-1:0] destRegIdx;
    logic [`REG_WIDTH-1:0]     destValue;   // store data, link pc or jmp target
  } decodedT;

endpackage

`default_nettype wire

/* design/scalarRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decodeStage_params.svh"

module scalarRegFile (
  input  wire                            I_CLOCK,
  input  wire                            reset,
  input  wire pipePkg::writeBackT        wb,
  input  wire [`REG_IDX_WIDTH-1:0]       read1Idx,
  input  wire [`REG_IDX_WIDTH-1:0]       read2Idx,
  input  wire [`REG_IDX_WIDTH-1:0]       read3Idx,
  output logic [`REG_WIDTH-1:0]          read1,
  output logic [`REG_WIDTH-1:0]          read2,
  output logic [`REG_WIDTH-1:0]          read3,
  output isaPkg::condCodeE               ccNow
);

  logic [`REG_WIDTH-1:0] regs [`NUM_REGS];
  isaPkg::condCodeE      ccReg;   // code of the last scalar writeback
  isaPkg::condCodeE      ccNext;

  // read port with same-cycle writeback bypass
  function automatic logic [`REG_WIDTH-1:0] readPort(input logic [`REG_IDX_WIDTH-1:0] idx);
    if (wb.enable && (wb.regIdx == idx))
      return wb.data;  // forwarded
    return regs[idx];
  endfunction

  // re-evaluated on wb and regs too, not only on the indices
  always_comb
  begin
    read1 = readPort(read1Idx);
    read2 = readPort(read2Idx);
    read3 = readPort(read3Idx);
  end

  // signed integer rule for every register
  always_comb
  begin
    if ($signed(wb.data) < 0)
      ccNext = isaPkg::ccN;
    else if (wb.data == '0)
      ccNext = isaPkg::ccZ;
    else
      ccNext = isaPkg::ccP;
  end

  assign ccNow = wb.enable ? ccNext : ccReg;  // branch sees this cycle's result

  always_ff @(posedge I_CLOCK)
  begin
    if (reset)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
      ccReg <= isaPkg::ccZ;
    end
    else if (wb.enable)
    begin
      regs[wb.regIdx] <= wb.data;
      ccReg           <= ccNext;
    end
  end

  // a write with a floating index would corrupt an unknown register
  wbIdxKnown : assert property (@(posedge I_CLOCK) disable iff (reset)
    wb.enable |-> !$isunknown(wb.regIdx));

endmodule

`default_nettype wire

/* design/scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decodeStage_params.svh"

module scoreboard (
  input  wire                       I_CLOCK,
  input  wire                       reset,
  input  wire                       lock,
  input  wire isaPkg::instrT        ir,
  input  wire pipePkg::writeBackT   wb,
  input  wire                       claimEnable,
  input  wire [`REG_IDX_WIDTH-1:0]  claimIdx,
  output logic                      depStallSignal,
  output logic                      branchStallSignal
);

  logic [`NUM_REGS-1:0] validBits;   // 1 = no write pending
  logic [`NUM_REGS-1:0] readyMask;   // valid or written this cycle
  logic                 needA;       // fieldA
  logic                 needB;       // fieldB
  logic                 needC;       // imm[11:8]
  logic                 needAll;     // branches wait for every register
  logic                 isJump;      // branch, jmp, jsr, jsrr
  logic                 srcBusy;

  assign readyMask = validBits | (wb.enable ? (`NUM_REGS'(1) << wb.regIdx) : '0);

  ////////////////////////////////////////////////////////////////////////////
  // source selection per opcode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    needA   = 1'b0;
    needB   = 1'b0;
    needC   = 1'b0;
    needAll = 1'b0;
    isJump  = 1'b0;
    case (ir.opcode)
      isaPkg::ADD, isaPkg::AND:
      begin
        needB = 1'b1;
        needC = 1'b1;
      end
      isaPkg::ADDI, isaPkg::ANDI, isaPkg::LDW: needB = 1'b1;
      isaPkg::MOV:               needC = 1'b1;
      isaPkg::STW:
      begin
        needA = 1'b1;
        needB = 1'b1;
      end
      isaPkg::JMP, isaPkg::JSRR:
      begin
        needB  = 1'b1;
        isJump = 1'b1;
      end
      isaPkg::JSR:               isJump = 1'b1;  // no register source
      default:
      begin
        if (ir.opcode[7:3] == isaPkg::BR_PREFIX)
        begin
          needAll = 1'b1;
          isJump  = 1'b1;
        end
      end
    endcase
  end

  assign srcBusy = (needA && !readyMask[ir.fieldA])
                || (needB && !readyMask[ir.fieldB])
                || (needC && !readyMask[ir.imm[11:8]])
                || (needAll && !(&readyMask));

  assign depStallSignal    = lock && srcBusy;
  assign branchStallSignal = lock && isJump && !depStallSignal;  // only once it can issue

  // claim is applied after the writeback set so it wins
  always_ff @(posedge I_CLOCK)
  begin
    if (reset)
      validBits <= '1;
    else
    begin
      if (wb.enable)
        validBits[wb.regIdx] <= 1'b1;
      if (claimEnable)
        validBits[claimIdx] <= 1'b0;
    end
  end

  // a stalled instruction must not invalidate its destination
  noClaimOnStall : assert property (@(posedge I_CLOCK) disable iff (reset)
    claimEnable |-> !depStallSignal);

endmodule

`default_nettype wire

/* design/operandDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decodeStage_params.svh"

module operandDecoder (
  input  wire                         I_CLOCK,
  input  wire                         reset,
  input  wire                         lock,
  input  wire [`PC_WIDTH-1:0]         pc,
  input  wire isaPkg::instrT          ir,
  input  wire                         depStallSignal,
  input  wire [`REG_WIDTH-1:0]        read1,
  input  wire [`REG_WIDTH-1:0]        read2,
  input  wire [`REG_WIDTH-1:0]        read3,
  input  wire isaPkg::condCodeE       ccNow,
  output logic [`REG_IDX_WIDTH-1:0]   read1Idx,
  output logic [`REG_IDX_WIDTH-1:0]   read2Idx,
  output logic [`REG_IDX_WIDTH-1:0]   read3Idx,
  output logic                        claimEnable,
  output logic [`REG_IDX_WIDTH-1:0]   claimIdx,
  output pipePkg::decodedT            decoded,
  output logic                        outLock,
  output logic                        depStall,
  output logic                        fetchStall
);

  localparam logic [`REG_IDX_WIDTH-1:0] LINK_IDX = `REG_IDX_WIDTH'(`LINK_REG);

  logic                  issue;       // valid and no hazard this cycle
  logic                  claimNeeded;
  logic [`REG_WIDTH-1:0] imm32;
  logic [`REG_WIDTH-1:0] immShift;    // word offset for jumps
  logic                  brTaken;

  assign read1Idx = ir.fieldB;
  assign read2Idx = ir.imm[11:8];
  assign read3Idx = ir.fieldA;

  assign issue    = lock && !depStallSignal;
  assign imm32    = {{(`REG_WIDTH - `IMM_WIDTH){ir.imm[`IMM_WIDTH-1]}}, ir.imm};
  assign immShift = imm32 << 2;
  assign brTaken  = |(3'(ccNow) & ir.opcode[2:0]);  // cc meets n/z/p mask

  ////////////////////////////////////////////////////////////////////////////
  // destination claim on the same edge as issue
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    claimNeeded = 1'b1;
    claimIdx    = ir.fieldA;
    case (ir.opcode)
      isaPkg::ADD, isaPkg::AND, isaPkg::ADDI, isaPkg::ANDI, isaPkg::LDW: ;
      isaPkg::MOV, isaPkg::MOVI: claimIdx = ir.fieldB;
      isaPkg::JSR, isaPkg::JSRR: claimIdx = LINK_IDX;
      default:                   claimNeeded = 1'b0;  // stw jmp and branches
    endcase
  end

  assign claimEnable = issue && claimNeeded;

  ////////////////////////////////////////////////////////////////////////////
  // decoded record and stall flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge I_CLOCK)
  begin
    if (reset)
    begin
      decoded    <= '0;
      outLock    <= 1'b0;
      depStall   <= 1'b0;
      fetchStall <= 1'b1;
    end
    else
    begin
      outLock <= lock;
      if (!lock)
        fetchStall <= 1'b1;  // nothing fetched so depStall holds
      else if (depStallSignal)
      begin
        depStall   <= 1'b1;  // record held
        fetchStall <= 1'b1;
      end
      else
      begin
        depStall       <= 1'b0;
        fetchStall     <= 1'b0;
        decoded.pc     <= pc;
        decoded.opcode <= ir.opcode;
        case (ir.opcode)
          isaPkg::ADD, isaPkg::AND:
          begin
            decoded.src1Value  <= read1;
            decoded.src2Value  <= read2;
            decoded.destRegIdx <= ir.fieldA;
          end
          isaPkg::ADDI, isaPkg::ANDI, isaPkg::LDW:
          begin
            decoded.src1Value  <= read1;
            decoded.imm        <= imm32;
            decoded.destRegIdx <= ir.fieldA;
          end
          isaPkg::MOV:
          begin
            decoded.src2Value  <= read2;
            decoded.destRegIdx <= ir.fieldB;
          end
          isaPkg::MOVI:
          begin
            decoded.imm        <= imm32;
            decoded.destRegIdx <= ir.fieldB;
          end
          isaPkg::STW:
          begin
            decoded.destValue <= read3;  // store data
            decoded.src1Value <= read1;  // base
            decoded.imm       <= imm32;
          end
          isaPkg::JSR:
          begin
            decoded.imm        <= immShift;
            decoded.destValue  <= pc;
            decoded.destRegIdx <= LINK_IDX;
          end
          isaPkg::JSRR:
          begin
            decoded.destValue  <= pc;
            decoded.destRegIdx <= LINK_IDX;
          end
          isaPkg::JMP: decoded.destValue <= read1;  // target
          default:
          begin
            // not taken gives a zero offset
            if (ir.opcode[7:3] == isaPkg::BR_PREFIX)
              decoded.imm <= brTaken ? immShift : '0;
          end
        endcase
      end
    end
  end

  // a valid instruction with floating bits would pick arbitrary fields
  irKnownOnLock : assert property (@(posedge I_CLOCK) disable iff (reset)
    lock |-> !$isunknown(ir));

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decodeStage_params.svh"

module decodeStage (
  input  wire                        I_CLOCK,
  input  wire                        reset,
  input  wire                        lock,
  input  wire [`PC_WIDTH-1:0]        pc,
  input  wire isaPkg::instrT         ir,
  input  wire pipePkg::writeBackT    wb,
  output pipePkg::decodedT           decoded,
  output logic                       outLock,
  output logic                       depStall,
  output logic                       fetchStall,
  output logic                       depStallSignal,
  output logic                       branchStallSignal
);

  logic [`REG_IDX_WIDTH-1:0] read1Idx;   // fieldB
  logic [`REG_IDX_WIDTH-1:0] read2Idx;   // imm[11:8]
  logic [`REG_IDX_WIDTH-1:0] read3Idx;   // fieldA
  logic [`REG_WIDTH-1:0]     read1;
  logic [`REG_WIDTH-1:0]     read2;
  logic [`REG_WIDTH-1:0]     read3;
  isaPkg::condCodeE          ccNow;      // forwarded condition code
  logic                      claimEnable;
  logic [`REG_IDX_WIDTH-1:0] claimIdx;

  scalarRegFile u_regFile (
    .I_CLOCK, .reset, .wb,
    .read1Idx, .read2Idx, .read3Idx,
    .read1, .read2, .read3,
    .ccNow
  );

  scoreboard u_scoreboard (
    .I_CLOCK, .reset, .lock, .ir, .wb,
    .claimEnable, .claimIdx,
    .depStallSignal, .branchStallSignal
  );

  operandDecoder u_decoder (
    .I_CLOCK, .reset, .lock, .pc, .ir, .depStallSignal,
    .read1, .read2, .read3, .ccNow,
    .read1Idx, .read2Idx, .read3Idx,
    .claimEnable, .claimIdx,
    .decoded, .outLock, .depStall, .fetchStall
  );

endmodule

`default_nettype wire

/* verification/decodeStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decodeStage_params.svh"

module decodeStageTb;

  localparam int HALF_PERIOD  = 20;      // 40 ns clock
  localparam int RESET_CYCLES = 10;
  localparam int MAX_PATTERNS = 1000;    // bound on the replay loop
  localparam int WATCHDOG_NS  = 200000;
  localparam int PATTERN_COLS = 19;

  logic                  I_CLOCK;
  logic                  reset;
  logic                  lock;
  logic [`PC_WIDTH-1:0]  pc;
  isaPkg::instrT         ir;
  pipePkg::writeBackT    wb;
  pipePkg::decodedT      decoded;
  logic                  outLock;
  logic                  depStall;
  logic                  fetchStall;
  logic                  depStallSignal;
  logic                  branchStallSignal;

  ////////////////////////////////////////////////////////////////////////////
  // one pattern line in file column order
  ////////////////////////////////////////////////////////////////////////////

  logic                      pLock;
  logic [`PC_WIDTH-1:0]      pPc;
  logic [`IR_WIDTH-1:0]      pIr;
  logic                      pWbEn;
  logic [`REG_IDX_WIDTH-1:0] pWbIdx;
  logic [`REG_WIDTH-1:0]     pWbData;
  logic                      pDepSig;       // combinational before the edge
  logic                      pBrSig;
  logic                      pIssue;        // 0 means decoded must hold
  logic [`PC_WIDTH-1:0]      ePc;
  logic [`OPCODE_WIDTH-1:0]  eOpcode;
  logic [`REG_WIDTH-1:0]     eImm;
  logic [`REG_WIDTH-1:0]     eSrc1;
  logic [`REG_WIDTH-1:0]     eSrc2;
  logic [`REG_IDX_WIDTH-1:0] eDest;
  logic [`REG_WIDTH-1:0]     eDestValue;
  logic                      eOutLock;      // registered and checked after the edge
  logic                      eDepStall;
  logic                      eFetchStall;

  pipePkg::decodedT          expRec;        // model of the held record

  decodeStage u_dut (
    .I_CLOCK, .reset, .lock, .pc, .ir, .wb,
    .decoded, .outLock, .depStall, .fetchStall,
    .depStallSignal, .branchStallSignal
  );

  initial I_CLOCK = 1'b0;
  always #(HALF_PERIOD) I_CLOCK = ~I_CLOCK;

  ////////////////////////////////////////////////////////////////////////////
  // failure handling and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic stopWithFailure();
    $display("ERRORS FOUND");
    $fatal(1, "decode stage run stopped");
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("error %s expected %h actual %h", name, expected, actual);
      stopWithFailure();
    end
  endtask

  task automatic checkDecoded(input pipePkg::decodedT expected, input pipePkg::decodedT actual);
    if (actual !== expected)
    begin
      $display("error decoded expected %h actual %h", expected, actual);
      stopWithFailure();
    end
  endtask

  // branch offset is the shifted imm when taken and zero otherwise
  task automatic checkCc(input isaPkg::opcodeE op, input logic [`REG_WIDTH-1:0] expected,
                         input logic [`REG_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("error decoded.imm (%s) expected %h actual %h", op.name(), expected, actual);
      stopWithFailure();
    end
  endtask

  // drive on the falling edge, then check both sides of the rising edge
  task automatic runPattern();
    lock = pLock;
    pc   = pPc;
    ir   = isaPkg::instrT'(pIr);
    wb   = '{enable: pWbEn, regIdx: pWbIdx, data: pWbData};
    #(HALF_PERIOD - 1);                  // just before the rising edge
    checkFlag("depStallSignal", pDepSig, depStallSignal);
    checkFlag("branchStallSignal", pBrSig, branchStallSignal);
    @(posedge I_CLOCK);
    #1;
    if (pIssue)
    begin
      expRec.pc         = ePc;
      expRec.opcode     = isaPkg::opcodeE'(eOpcode);
      expRec.imm        = eImm;
      expRec.src1Value  = eSrc1;
      expRec.src2Value  = eSrc2;
      expRec.destRegIdx = eDest;
      expRec.destValue  = eDestValue;
      if (expRec.opcode[7:3] == isaPkg::BR_PREFIX)
        checkCc(expRec.opcode, expRec.imm, decoded.imm);
    end
    checkDecoded(expRec, decoded);       // held value when nothing issued
    checkFlag("outLock", eOutLock, outLock);
    checkFlag("depStall", eDepStall, depStall);
    checkFlag("fetchStall", eFetchStall, fetchStall);
    @(negedge I_CLOCK);
  endtask

  // branch in ir with lock low while claims are still pending
  // neither stall signal may rise, depStall keeps the last expected value
  task automatic checkIdleBranch();
    pLock       = 1'b0;
    pPc         = '0;
    pIr         = {isaPkg::BRNZP, 24'h000001};
    pWbEn       = 1'b0;
    pDepSig     = 1'b0;
    pBrSig      = 1'b0;
    pIssue      = 1'b0;
    eOutLock    = 1'b0;
    eFetchStall = 1'b1;
    runPattern();
  endtask

  // hang guard for the whole run
  initial
  begin
    #(WATCHDOG_NS);
    $display("simulation did not reach the end of the patterns in time");
    stopWithFailure();
  end

  ////////////////////////////////////////////////////////////////////////////
  // reset then replay of the pattern file
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int fd;
    int status;
    int patternCount;
    int cycle;
    reset  = 1'b1;
    lock   = 1'b0;
    pc     = '0;
    ir     = '0;
    wb     = '0;
    expRec = '0;
    for (cycle = 0; cycle < RESET_CYCLES; cycle++)
      @(posedge I_CLOCK);
    @(negedge I_CLOCK);
    reset = 1'b0;
    checkFlag("outLock", 1'b0, outLock);   // reset state
    checkFlag("depStall", 1'b0, depStall);
    checkFlag("fetchStall", 1'b1, fetchStall);
    checkDecoded(expRec, decoded);

    fd = $fopen("verification/decodeStagePatterns.txt", "r");
    if (fd == 0)
    begin
      $display("pattern file verification/decodeStagePatterns.txt could not be opened");
      stopWithFailure();
    end
    patternCount = 0;
    status       = 0;
    while (status != -1)
    begin
      status = $fscanf(fd,
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        pLock, pPc, pIr, pWbEn, pWbIdx, pWbData, pDepSig, pBrSig, pIssue,
        ePc, eOpcode, eImm, eSrc1, eSrc2, eDest, eDestValue,
        eOutLock, eDepStall, eFetchStall);
      if (status == PATTERN_COLS)
      begin
        runPattern();
        patternCount++;
        if (patternCount > MAX_PATTERNS)
        begin
          $display("pattern file has more than %0d lines", MAX_PATTERNS);
          stopWithFailure();
        end
      end
      else if (status != -1)
      begin
        $display("pattern line %0d is incomplete", patternCount + 1);
        stopWithFailure();
      end
    end
    $fclose(fd);

    if (patternCount == 0)
    begin
      $display("pattern file holds no patterns");
      stopWithFailure();
    end
    else
    begin
      checkIdleBranch();
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* decodeStage.f */
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/scalarRegFile.sv
design/scoreboard.sv
design/operandDecoder.sv
design/decodeStage.sv
verification/decodeStageTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the decode stage testbench with verilator
# exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f decodeStage.f --top-module decodeStageTb -Mdir obj_dir
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit $buildStatus
fi

./obj_dir/VdecodeStageTb
runStatus=$?
if [ $runStatus -ne 0 ]; then
  echo "simulation failed with status $runStatus"
  exit $runStatus
fi

exit 0

/* verification/decodeStagePatterns.txt */
0 00000000 00000000 1 1 00000011 0 0 0 00000000 00 00000000 00000000 00000000 0 00000000 0 0 1
0 00000000 00000000 1 2 00000022 0 0 0 00000000 00 00000000 00000000 00000000 0 00000000 0 0 1
1 00000100 05038005 0 0 00000000 0 0 1 00000100 05 FFFF8005 00000000 00000000 3 00000000 1 0 0
1 00000104 00410200 0 0 00000000 0 0 1 00000104 00 FFFF8005 00000011 00000022 4 00000000 1 0 0
1 00000108 00530100 0 0 00000000 1 0 0 00000000 00 00000000 00000000 00000000 0 00000000 1 1 1
1 00000108 00530100 1 4 00000044 1 0 0 00000000 00 00000000 00000000 00000000 0 00000000 1 1 1
1 00000108 00530100 1 3 FFFFFFF0 0 0 1 00000108 00 FFFF8005 FFFFFFF0 00000011 5 00000000 1 0 0
0 00000000 00000000 1 5 00000055 0 0 0 00000000 00 00000000 00000000 00000000 0 00000000 0 0 1
1 0000010C 11210010 0 0 00000000 0 0 1 0000010C 11 00000010 00000011 00000011 5 00000022 1 0 0
1 00000110 1064FFFC 0 0 00000000 0 0 1 00000110 10 FFFFFFFC 00000044 00000011 6 00000022 1 0 0
1 00000114 30040000 0 0 00000000 0 1 1 00000114 30 FFFFFFFC 00000044 00000011 6 00000044 1 0 0
1 00000118 32010000 0 0 00000000 0 1 1 00000118 32 FFFFFFFC 00000044 00000011 7 00000118 1 0 0
1 0000011C 31000003 0 0 00000000 0 1 1 0000011C 31 0000000C 00000044 00000011 7 0000011C 1 0 0
1 00000120 22000010 0 0 00000000 1 0 0 00000000 00 00000000 00000000 00000000 0 00000000 1 1 1
0 00000000 00000000 1 6 00000000 0 0 0 00000000 00 00000000 00000000 00000000 0 00000000 0 1 1
1 00000120 22000010 1 7 00000000 0 1 1 00000120 22 00000040 00000044 00000011 7 0000011C 1 0 0
1 00000124 21000008 0 0 00000000 0 1 1 00000124 21 00000000 00000044 00000011 7 0000011C 1 0 0
1 00000128 25000008 0 0 00000000 0 1 1 00000128 25 00000000 00000044 00000011 7 0000011C 1 0 0
1 0000012C 2300FFFF 0 0 00000000 0 1 1 0000012C 23 FFFFFFFC 00000044 00000011 7 0000011C 1 0 0
1 00000130 24000004 1 8 80000000 0 1 1 00000130 24 00000010 00000044 00000011 7 0000011C 1 0 0
1 00000134 26000005 0 0 00000000 0 1 1 00000134 26 00000014 00000044 00000011 7 0000011C 1 0 0
1 00000138 21000006 1 9 00000001 0 1 1 00000138 21 00000018 00000044 00000011 7 0000011C 1 0 0
1 0000013C 22000007 0 0 00000000 0 1 1 0000013C 22 00000000 00000044 00000011 7 0000011C 1 0 0
1 00000140 27000002 0 0 00000000 0 1 1 00000140 27 00000008 00000044 00000011 7 0000011C 1 0 0
1 00000144 24000003 0 0 00000000 0 1 1 00000144 24 00000000 00000044 00000011 7 0000011C 1 0 0
1 00000148 26000009 1 A 00000000 0 1 1 00000148 26 00000024 00000044 00000011 7 0000011C 1 0 0
1 0000014C 2500000A 0 0 00000000 0 1 1 0000014C 25 00000000 00000044 00000011 7 0000011C 1 0 0
1 00000150 04080900 0 0 00000000 0 0 1 00000150 04 00000000 00000044 00000001 8 0000011C 1 0 0
1 00000154 040B0800 0 0 00000000 1 0 0 00000000 00 00000000 00000000 00000000 0 00000000 1 1 1
0 00000000 00000000 0 0 00000000 0 0 0 00000000 00 00000000 00000000 00000000 0 00000000 0 1 1
1 00000154 040B0800 1 8 00000088 0 0 1 00000154 04 00000000 00000044 00000088 B 0000011C 1 0 0
1 00000158 03CB00FF 0 0 00000000 1 0 0 00000000 00 00000000 00000000 00000000 0 00000000 1 1 1
1 00000158 03CB00FF 1 B 000000BB 0 0 1 00000158 03 000000FF 000000BB 00000088 C 0000011C 1 0 0
1 0000015C 02D10300 0 0 00000000 0 0 1 0000015C 02 000000FF 00000011 FFFFFFF0 D 0000011C 1 0 0
1 00000160 01E00001 0 0 00000000 0 0 1 00000160 01 00000001 00000000 FFFFFFF0 E 0000011C 1 0 0
0 00000000 00000000 0 0 00000000 0 0 0 00000000 00 00000000 00000000 00000000 0 00000000 0 0 1
